/* core.sv */
`default_nettype none
`include "core_params.svh"

module core (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  inst_start,
	input  logic                  inst_ready,
	output logic [`CORE_XLEN-1:0] inst_addr,
	input  logic [`CORE_XLEN-1:0] inst_data,
	input  logic                  inst_valid,
	output core_pkg::mem_cmd_e    d_cmd,
	input  logic                  d_cmd_ready,
	output logic [`CORE_XLEN-1:0] d_addr,
	output logic [`CORE_XLEN-1:0] d_wdata,
	output logic [3:0]            d_wmask,
	input  logic [`CORE_XLEN-1:0] d_rdata,
	input  logic                  d_rdata_valid
);

	core_pkg::if_id_s    if_id;
	core_pkg::id_ex_s    id_ex;
	core_pkg::ex_mem_s   ex_mem;
	core_pkg::wb_s       wb;
	core_pkg::redirect_s redirect;
	// Data port stall freezes every stage
	logic                stall;
	logic                hold;

	// ******************************************************************
	// Front end
	// ******************************************************************
	fetch_stage fetch_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.redirect   (redirect),
		.hold       (hold),
		.inst_start (inst_start),
		.inst_ready (inst_ready),
		.inst_addr  (inst_addr),
		.inst_data  (inst_data),
		.inst_valid (inst_valid),
		.if_id      (if_id)
	);

	decode_stage decode_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.hold_out    (hold),
		.redirect    (redirect),
		.if_id       (if_id),
		.ex_rd_busy  (id_ex),
		.mem_rd_busy (ex_mem),
		.wb          (wb),
		.id_ex       (id_ex)
	);

	// ******************************************************************
	// Back end
	// ******************************************************************
	execute_stage execute_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.id_ex    (id_ex),
		.redirect (redirect),
		.ex_mem   (ex_mem)
	);

	memory_stage memory_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex_mem        (ex_mem),
		.stall         (stall),
		.wb            (wb),
		.d_cmd         (d_cmd),
		.d_cmd_ready   (d_cmd_ready),
		.d_addr        (d_addr),
		.d_wdata       (d_wdata),
		.d_wmask       (d_wmask),
		.d_rdata       (d_rdata),
		.d_rdata_valid (d_rdata_valid)
	);

endmodule

`default_nettype wire

/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Data path and address width in bits
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NREGS 32

`endif

/* core_pkg.sv */
`default_nettype none
`include "core_params.svh"

package core_pkg;

	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	// Data port command encoding
	typedef enum logic [2:0] {
		MEM_NONE  = 3'd0,
		MEM_READ  = 3'd1,
		MEM_WRITE = 3'd2
	} mem_cmd_e;

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		logic [`CORE_XLEN-1:0] inst;
	} if_id_s;

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		alu_op_e               alu_op;
		logic [`CORE_XLEN-1:0] op1;
		logic [`CORE_XLEN-1:0] op2;
		logic [`CORE_XLEN-1:0] rs2_data;
		logic [`CORE_XLEN-1:0] imm;
		logic                  is_branch;
		logic                  branch_ne;
		logic                  is_jal;
		mem_cmd_e              mem_cmd;
		logic                  is_byte;
		wb_sel_e               wb_sel;
		reg_idx_t              rd;
	} id_ex_s;

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] alu_out;
		logic [`CORE_XLEN-1:0] rs2_data;
		logic [`CORE_XLEN-1:0] pc_plus4;
		mem_cmd_e              mem_cmd;
		logic                  is_byte;
		wb_sel_e               wb_sel;
		reg_idx_t              rd;
	} ex_mem_s;

	// Register file write from the memory stage
	typedef struct packed {
		logic                  wen;
		reg_idx_t              rd;
		logic [`CORE_XLEN-1:0] data;
	} wb_s;

	typedef struct packed {
		logic                  taken;
		logic [`CORE_XLEN-1:0] target;
	} redirect_s;

endpackage

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`include "core_params.svh"

module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	output logic                hold_out,
	input  core_pkg::redirect_s redirect,
	input  core_pkg::if_id_s    if_id,
	input  core_pkg::id_ex_s    ex_rd_busy,
	input  core_pkg::ex_mem_s   mem_rd_busy,
	input  core_pkg::wb_s       wb,
	output core_pkg::id_ex_s    id_ex
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
	core_pkg::reg_idx_t    rs1;
	core_pkg::reg_idx_t    rs2;
	logic [2:0]            funct3;
	logic [`CORE_XLEN-1:0] rs1_data;
	logic [`CORE_XLEN-1:0] rs2_data;
	logic [`CORE_XLEN-1:0] imm_i;
	logic [`CORE_XLEN-1:0] imm_s;
	logic [`CORE_XLEN-1:0] imm_b;
	logic [`CORE_XLEN-1:0] imm_u;
	logic [`CORE_XLEN-1:0] imm_j;
	logic                  use_rs1;
	logic                  use_rs2;
	logic                  ex_wr;
	logic                  mem_wr;
	logic                  hazard;
	core_pkg::id_ex_s      dec;

	assign rs1    = if_id.inst[19:15];
	assign rs2    = if_id.inst[24:20];
	assign funct3 = if_id.inst[14:12];

	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
		if_id.inst[30:25], if_id.inst[11:8], 1'b0};
	assign imm_u = {if_id.inst[31:12], 12'b0};
	assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
		if_id.inst[20], if_id.inst[30:21], 1'b0};

	// ******************************************************************
	// Register file, write first so write-back needs no interlock
	// ******************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs[0] <= '0;
		else if (wb.wen && wb.rd != '0)
			regs[wb.rd] <= wb.data;
	end

	assign rs1_data = (wb.wen && wb.rd == rs1 && rs1 != '0) ? wb.data : regs[rs1];
	assign rs2_data = (wb.wen && wb.rd == rs2 && rs2 != '0) ? wb.data : regs[rs2];

	// ******************************************************************
	// Instruction decode
	// ******************************************************************
	always_comb begin
		dec          = '0;
		dec.valid    = if_id.valid;
		dec.pc       = if_id.pc;
		dec.alu_op   = core_pkg::ALU_ADD;
		dec.op1      = rs1_data;
		dec.op2      = rs2_data;
		dec.rs2_data = rs2_data;
		dec.imm      = imm_i;
		dec.mem_cmd  = core_pkg::MEM_NONE;
		dec.wb_sel   = core_pkg::WB_NONE;
		dec.rd       = if_id.inst[11:7];
		use_rs1      = 1'b0;
		use_rs2      = 1'b0;
		case (if_id.inst[6:0])
			core_pkg::OPC_LUI: begin
				dec.alu_op = core_pkg::ALU_PASS_B;
				dec.op2    = imm_u;
				dec.wb_sel = core_pkg::WB_ALU;
			end
			core_pkg::OPC_OP_IMM, core_pkg::OPC_OP: begin
				use_rs1    = 1'b1;
				use_rs2    = (if_id.inst[6:0] == core_pkg::OPC_OP);
				dec.wb_sel = core_pkg::WB_ALU;
				if (!use_rs2)
					dec.op2 = imm_i;
				case (funct3)
					3'b000: begin
						dec.alu_op = (use_rs2 && if_id.inst[30]) ?
							core_pkg::ALU_SUB : core_pkg::ALU_ADD;
					end
					3'b010:  dec.alu_op = core_pkg::ALU_SLT;
					3'b100:  dec.alu_op = core_pkg::ALU_XOR;
					3'b110:  dec.alu_op = core_pkg::ALU_OR;
					3'b111:  dec.alu_op = core_pkg::ALU_AND;
					// Shifts and SLTU fall through as no-ops
					default: dec.wb_sel = core_pkg::WB_NONE;
				endcase
			end
			core_pkg::OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					use_rs1     = 1'b1;
					dec.op2     = imm_i;
					dec.mem_cmd = core_pkg::MEM_READ;
					dec.wb_sel  = core_pkg::WB_MEM;
				end
			end
			core_pkg::OPC_STORE: begin
				if (funct3 == 3'b010 || funct3 == 3'b000) begin
					use_rs1     = 1'b1;
					use_rs2     = 1'b1;
					dec.op2     = imm_s;
					dec.mem_cmd = core_pkg::MEM_WRITE;
					dec.is_byte = (funct3 == 3'b000);
				end
			end
			core_pkg::OPC_BRANCH: begin
				if (funct3[2:1] == 2'b00) begin
					use_rs1       = 1'b1;
					use_rs2       = 1'b1;
					dec.is_branch = 1'b1;
					dec.branch_ne = funct3[0];
					dec.imm       = imm_b;
				end
			end
			core_pkg::OPC_JAL: begin
				dec.is_jal = 1'b1;
				dec.imm    = imm_j;
				dec.wb_sel = core_pkg::WB_PC4;
			end
			default: begin
			end
		endcase
	end

	// ******************************************************************
	// RAW interlock against execute and memory
	// ******************************************************************
	assign ex_wr  = ex_rd_busy.valid && ex_rd_busy.wb_sel != core_pkg::WB_NONE;
	// Result being written this cycle comes through the bypass
	assign mem_wr = mem_rd_busy.valid && mem_rd_busy.wb_sel != core_pkg::WB_NONE && !wb.wen;

	assign hazard = if_id.valid && (
		(use_rs1 && rs1 != '0 && ((ex_wr && ex_rd_busy.rd == rs1) ||
			(mem_wr && mem_rd_busy.rd == rs1))) ||
		(use_rs2 && rs2 != '0 && ((ex_wr && ex_rd_busy.rd == rs2) ||
			(mem_wr && mem_rd_busy.rd == rs2))));
	assign hold_out = hazard;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (redirect.taken) begin
			id_ex.valid <= 1'b0;
		end else if (!stall) begin
			id_ex       <= dec;
			id_ex.valid <= dec.valid && !hazard;
		end
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`include "core_params.svh"

module execute_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  core_pkg::id_ex_s    id_ex,
	output core_pkg::redirect_s redirect,
	output core_pkg::ex_mem_s   ex_mem
);

	logic [`CORE_XLEN-1:0] alu_out;
	logic                  br_taken;

	always_comb begin
		case (id_ex.alu_op)
			core_pkg::ALU_ADD:    alu_out = id_ex.op1 + id_ex.op2;
			core_pkg::ALU_SUB:    alu_out = id_ex.op1 - id_ex.op2;
			core_pkg::ALU_AND:    alu_out = id_ex.op1 & id_ex.op2;
			core_pkg::ALU_OR:     alu_out = id_ex.op1 | id_ex.op2;
			core_pkg::ALU_XOR:    alu_out = id_ex.op1 ^ id_ex.op2;
			core_pkg::ALU_SLT: begin
				alu_out = ($signed(id_ex.op1) < $signed(id_ex.op2)) ? 32'd1 : 32'd0;
			end
			core_pkg::ALU_PASS_B: alu_out = id_ex.op2;
			default:              alu_out = id_ex.op1 + id_ex.op2;
		endcase
	end

	// BEQ on equal, BNE on not equal
	assign br_taken = id_ex.is_branch &&
		((id_ex.op1 == id_ex.rs2_data) != id_ex.branch_ne);

	// Pulses once, the branch leaves execute on the same edge
	assign redirect.taken  = id_ex.valid && !stall && (br_taken || id_ex.is_jal);
	assign redirect.target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (!stall) begin
			ex_mem.valid    <= id_ex.valid;
			ex_mem.alu_out  <= alu_out;
			ex_mem.rs2_data <= id_ex.rs2_data;
			ex_mem.pc_plus4 <= id_ex.pc + 32'd4;
			ex_mem.mem_cmd  <= id_ex.mem_cmd;
			ex_mem.is_byte  <= id_ex.is_byte;
			ex_mem.wb_sel   <= id_ex.wb_sel;
			ex_mem.rd       <= id_ex.rd;
		end
	end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`default_nettype none
`include "core_params.svh"

module fetch_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  core_pkg::redirect_s   redirect,
	input  logic                  hold,
	output logic                  inst_start,
	input  logic                  inst_ready,
	output logic [`CORE_XLEN-1:0] inst_addr,
	input  logic [`CORE_XLEN-1:0] inst_data,
	input  logic                  inst_valid,
	output core_pkg::if_id_s      if_id
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT
	} fetch_state_e;

	fetch_state_e          state;
	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] addr_q;
	logic [`CORE_XLEN-1:0] fetch_pc;
	logic                  drop;
	logic                  can_load;
	core_pkg::if_id_s      resp;
	core_pkg::if_id_s      buf_q;

	assign inst_start = (state == REQ);
	assign inst_addr  = addr_q;
	assign fetch_pc   = redirect.taken ? redirect.target : pc;
	// Slot is empty or decode takes it this cycle
	assign can_load   = !if_id.valid || (!stall && !hold);

	// Returned word, valid only if it is still on the current path
	assign resp.valid = (state == WAIT) && inst_valid && !drop && !redirect.taken;
	assign resp.pc    = addr_q;
	assign resp.inst  = inst_data;

	// Request FSM with a single request outstanding
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			pc     <= `CORE_RESET_PC;
			addr_q <= `CORE_RESET_PC;
			drop   <= 1'b0;
		end else begin
			if (redirect.taken)
				pc <= redirect.target;
			case (state)
				IDLE: begin
					if (!buf_q.valid || can_load || redirect.taken) begin
						state  <= REQ;
						addr_q <= fetch_pc;
						pc     <= fetch_pc + 32'd4;
					end
				end
				REQ: begin
					if (inst_ready)
						state <= WAIT;
					// Old request still completes, its word is thrown away
					if (redirect.taken)
						drop <= 1'b1;
				end
				default: begin
					if (inst_valid) begin
						state <= IDLE;
						drop  <= 1'b0;
					end else if (redirect.taken) begin
						drop <= 1'b1;
					end
				end
			endcase
		end
	end

	// Fetch-to-decode register plus one spare word for stalls
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0;
			buf_q <= '0;
		end else if (redirect.taken) begin
			if_id.valid <= 1'b0;
			buf_q.valid <= 1'b0;
		end else if (can_load) begin
			if_id       <= buf_q.valid ? buf_q : resp;
			buf_q.valid <= 1'b0;
		end else if (resp.valid) begin
			buf_q <= resp;
		end
	end

	// Address must not move before the port takes the request
	a_inst_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		inst_start && !inst_ready |=> inst_start && $stable(inst_addr));

endmodule

`default_nettype wire

/* memory_stage.sv */
`default_nettype none
`include "core_params.svh"

module memory_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_pkg::ex_mem_s     ex_mem,
	output logic                  stall,
	output core_pkg::wb_s         wb,
	output core_pkg::mem_cmd_e    d_cmd,
	input  logic                  d_cmd_ready,
	output logic [`CORE_XLEN-1:0] d_addr,
	output logic [`CORE_XLEN-1:0] d_wdata,
	output logic [3:0]            d_wmask,
	input  logic [`CORE_XLEN-1:0] d_rdata,
	input  logic                  d_rdata_valid
);

	typedef enum logic {
		M_ISSUE,
		M_READ_WAIT
	} mem_state_e;

	mem_state_e state;
	logic       issue;

	assign issue = ex_mem.valid && ex_mem.mem_cmd != core_pkg::MEM_NONE &&
		state == M_ISSUE;

	assign d_cmd   = issue ? ex_mem.mem_cmd : core_pkg::MEM_NONE;
	assign d_addr  = {ex_mem.alu_out[`CORE_XLEN-1:2], 2'b00};
	// SB lane from the low address bits, byte copied to all lanes
	assign d_wmask = ex_mem.is_byte ? (4'b0001 << ex_mem.alu_out[1:0]) : 4'b1111;
	assign d_wdata = ex_mem.is_byte ? {4{ex_mem.rs2_data[7:0]}} : ex_mem.rs2_data;

	// Writes finish at acceptance, reads when the data returns
	always_comb begin
		if (issue)
			stall = !(ex_mem.mem_cmd == core_pkg::MEM_WRITE && d_cmd_ready);
		else
			stall = (state == M_READ_WAIT) && !d_rdata_valid;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= M_ISSUE;
		else if (issue && ex_mem.mem_cmd == core_pkg::MEM_READ && d_cmd_ready)
			state <= M_READ_WAIT;
		else if (state == M_READ_WAIT && d_rdata_valid)
			state <= M_ISSUE;
	end

	// Write-back happens as the instruction leaves this stage
	always_comb begin
		wb.wen = ex_mem.valid && ex_mem.wb_sel != core_pkg::WB_NONE && !stall;
		wb.rd  = ex_mem.rd;
		case (ex_mem.wb_sel)
			core_pkg::WB_MEM: wb.data = d_rdata;
			core_pkg::WB_PC4: wb.data = ex_mem.pc_plus4;
			default:          wb.data = ex_mem.alu_out;
		endcase
	end

	a_rdata_expected: assert property (@(posedge clk) disable iff (!rst_n)
		d_rdata_valid |-> state == M_READ_WAIT);

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
core_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core.sv
tb_memory.sv
tb_checker.sv
tb_core.sv

/* tb_checker.sv */
`default_nettype none

module tb_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::mem_cmd_e d_cmd,
	input  logic               d_cmd_ready,
	input  logic [31:0]        d_addr,
	input  logic [31:0]        d_wdata,
	input  logic [3:0]         d_wmask,
	output int                 passed,
	output int                 failed
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESULT_ADDR = 32'h0000_0100;

	event        done;
	logic        armed;
	string       test_label;
	logic [31:0] exp_data;
	logic [3:0]  exp_mask;
	logic [31:0] lanes;
	logic        ok;

	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	// Expected result for the next store to the result word
	task automatic arm(input string test, input logic [31:0] data, input logic [3:0] mask);
		test_label = test;
		exp_data   = data;
		exp_mask   = mask;
		armed      = 1'b1;
	endtask

	initial begin
		passed = 0;
		failed = 0;
		armed  = 1'b0;
	end

	// Sampled at the edge where the write is accepted
	always @(posedge clk) begin
		if (rst_n && armed && d_cmd == core_pkg::MEM_WRITE && d_cmd_ready &&
				d_addr == RESULT_ADDR) begin
			ok    = 1'b1;
			lanes = lane_bits(exp_mask);
			if (d_wmask !== exp_mask) begin
				$display("[FAIL] %0t ns %s d_wmask: got %b, expected %b",
					$time, test_label, d_wmask, exp_mask);
				ok = 1'b0;
			end
			if ((d_wdata & lanes) !== (exp_data & lanes)) begin
				$display("[FAIL] %0t ns %s d_wdata: got %h, expected %h",
					$time, test_label, d_wdata & lanes, exp_data & lanes);
				ok = 1'b0;
			end
			if (ok) begin
				passed++;
				$display("[PASS] %0t ns %s d_wdata %h", $time, test_label, d_wdata & lanes);
			end else begin
				failed++;
			end
			armed = 1'b0;
			-> done;
		end
	end

endmodule

`default_nettype wire

/* tb_core.sv */
`default_nettype none

module tb_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int         NUM_TESTS       = 5;
	localparam int         MAX_WORDS       = 16;
	localparam int         CYCLES_PER_TEST = 400;
	localparam logic [6:0] OPC_IMM         = 7'b0010011;
	localparam logic [6:0] OPC_LOAD        = 7'b0000011;
	localparam logic [6:0] F7_SUB          = 7'b0100000;

	logic               clk;
	logic               rst_n;
	logic               inst_start;
	logic               inst_ready;
	logic [31:0]        inst_addr;
	logic [31:0]        inst_data;
	logic               inst_valid;
	core_pkg::mem_cmd_e d_cmd;
	logic               d_cmd_ready;
	logic [31:0]        d_addr;
	logic [31:0]        d_wdata;
	logic [3:0]         d_wmask;
	logic [31:0]        d_rdata;
	logic               d_rdata_valid;
	int                 passed;
	int                 failed;
	int                 cycles = 0;

	// Program table, one row per test
	logic [31:0] prog [NUM_TESTS][MAX_WORDS];
	int          prog_len [NUM_TESTS];
	logic [31:0] exp_data [NUM_TESTS];
	logic [3:0]  exp_mask [NUM_TESTS];
	string       test_name [NUM_TESTS];
	int          cur;

	core core_inst (
		.clk (clk), .rst_n (rst_n),
		.inst_start (inst_start), .inst_ready (inst_ready), .inst_addr (inst_addr),
		.inst_data (inst_data), .inst_valid (inst_valid),
		.d_cmd (d_cmd), .d_cmd_ready (d_cmd_ready), .d_addr (d_addr),
		.d_wdata (d_wdata), .d_wmask (d_wmask),
		.d_rdata (d_rdata), .d_rdata_valid (d_rdata_valid)
	);

	tb_memory memory_model (
		.clk (clk), .rst_n (rst_n),
		.inst_start (inst_start), .inst_ready (inst_ready), .inst_addr (inst_addr),
		.inst_data (inst_data), .inst_valid (inst_valid),
		.d_cmd (d_cmd), .d_cmd_ready (d_cmd_ready), .d_addr (d_addr),
		.d_wdata (d_wdata), .d_wmask (d_wmask),
		.d_rdata (d_rdata), .d_rdata_valid (d_rdata_valid)
	);

	tb_checker result_checker (
		.clk (clk), .rst_n (rst_n),
		.d_cmd (d_cmd), .d_cmd_ready (d_cmd_ready), .d_addr (d_addr),
		.d_wdata (d_wdata), .d_wmask (d_wmask),
		.passed (passed), .failed (failed)
	);

	// ******************************************************************
	// RV32I instruction encoders
	// ******************************************************************
	function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] imm_op(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] store_op(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] upper_op(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] jump_op(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic begin_test(input string name, input logic [31:0] data,
		input logic [3:0] mask);
		cur++;
		test_name[cur] = name;
		exp_data[cur]  = data;
		exp_mask[cur]  = mask;
		prog_len[cur]  = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		prog[cur][prog_len[cur]] = word;
		prog_len[cur]++;
	endtask

	// x10 holds the result address 0x100 in every program
	task automatic build_table();
		cur = -1;
		// x9 = ((x4 ^ x2 | x1) & x2) + 1 with x4 = 2*x2 - x1
		begin_test("arith_chain", 32'h1234_5209, 4'b1111);
		emit(imm_op(OPC_IMM, 3'b000, 10, 0, 32'h100));
		emit(upper_op(1, 20'h12345));
		emit(imm_op(OPC_IMM, 3'b000, 2, 1, 32'h678));
		emit(reg_op(7'd0, 3'b000, 3, 2, 2));
		emit(reg_op(F7_SUB, 3'b000, 4, 3, 1));
		emit(reg_op(7'd0, 3'b100, 5, 4, 2));
		emit(reg_op(7'd0, 3'b110, 6, 5, 1));
		emit(reg_op(7'd0, 3'b111, 7, 6, 2));
		emit(reg_op(7'd0, 3'b010, 8, 5, 7));
		emit(reg_op(7'd0, 3'b000, 9, 7, 8));
		emit(store_op(3'b010, 9, 10, 0));
		emit(jump_op(0, 0));

		// Word round trip through 0x140, then minus 5
		begin_test("store_load", 32'hcafe_011e, 4'b1111);
		emit(imm_op(OPC_IMM, 3'b000, 10, 0, 32'h100));
		emit(upper_op(1, 20'hcafe0));
		emit(imm_op(OPC_IMM, 3'b000, 1, 1, 32'h123));
		emit(store_op(3'b010, 1, 10, 32'h40));
		emit(imm_op(OPC_LOAD, 3'b010, 2, 10, 32'h40));
		emit(imm_op(OPC_IMM, 3'b000, 3, 2, -5));
		emit(store_op(3'b010, 3, 10, 0));
		emit(jump_op(0, 0));

		// Low byte lands in lane 2 only
		begin_test("store_byte", 32'h00a5_0000, 4'b0100);
		emit(imm_op(OPC_IMM, 3'b000, 10, 0, 32'h100));
		emit(imm_op(OPC_IMM, 3'b000, 1, 0, 32'h7a5));
		emit(store_op(3'b000, 1, 10, 2));
		emit(jump_op(0, 0));

		// BNE falls through, BEQ jumps over three poison adds
		begin_test("branches", 32'h0000_0111, 4'b1111);
		emit(imm_op(OPC_IMM, 3'b000, 10, 0, 32'h100));
		emit(imm_op(OPC_IMM, 3'b000, 1, 0, 7));
		emit(imm_op(OPC_IMM, 3'b000, 2, 0, 7));
		emit(imm_op(OPC_IMM, 3'b000, 3, 0, 32'h11));
		emit(branch_op(3'b001, 1, 2, 24));
		emit(imm_op(OPC_IMM, 3'b000, 3, 3, 32'h100));
		emit(branch_op(3'b000, 1, 2, 16));
		emit(imm_op(OPC_IMM, 3'b000, 3, 3, 32'h200));
		emit(imm_op(OPC_IMM, 3'b000, 3, 3, 32'h400));
		emit(imm_op(OPC_IMM, 3'b000, 3, 3, 32'h040));
		emit(store_op(3'b010, 3, 10, 0));
		emit(jump_op(0, 0));

		// JAL at 0x04 links 0x08 into x5
		begin_test("jal_link", 32'h0000_0008, 4'b1111);
		emit(imm_op(OPC_IMM, 3'b000, 10, 0, 32'h100));
		emit(jump_op(5, 12));
		emit(imm_op(OPC_IMM, 3'b000, 5, 0, 32'h333));
		emit(imm_op(OPC_IMM, 3'b000, 5, 0, 32'h444));
		emit(store_op(3'b010, 5, 10, 0));
		emit(jump_op(0, 0));
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= NUM_TESTS * CYCLES_PER_TEST) begin
			$display("Timeout: the tests did not finish within %0d cycles",
				NUM_TESTS * CYCLES_PER_TEST);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(negedge clk);
			rst_n = 1'b0;
			// Program goes in while the core sits in reset
			memory_model.clear_memory();
			for (int w = 0; w < prog_len[t]; w++)
				memory_model.write_word(w, prog[t][w]);
			result_checker.arm(test_name[t], exp_data[t], exp_mask[t]);
			repeat (4) @(negedge clk);
			rst_n = 1'b1;
			@(result_checker.done);
		end
		$display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
		if (failed == 0 && passed == NUM_TESTS)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_memory.sv */
`default_nettype none

module tb_memory (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               inst_start,
	output logic               inst_ready,
	input  logic [31:0]        inst_addr,
	output logic [31:0]        inst_data,
	output logic               inst_valid,
	input  core_pkg::mem_cmd_e d_cmd,
	output logic               d_cmd_ready,
	input  logic [31:0]        d_addr,
	input  logic [31:0]        d_wdata,
	input  logic [3:0]         d_wmask,
	output logic [31:0]        d_rdata,
	output logic               d_rdata_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORDS = 256;

	logic [31:0]        mem [WORDS];
	logic [31:0]        lfsr = 32'hb8d5;
	int                 i_cnt;
	logic               i_busy;
	logic [31:0]        i_addr;
	int                 d_cnt;
	logic               d_busy;
	core_pkg::mem_cmd_e d_op;
	logic [31:0]        d_a;
	logic [31:0]        d_wd;
	logic [31:0]        lanes;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Two LFSR bits, so 0 to 3 cycles
	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			d = (d << 1) | lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic clear_memory();
		for (int a = 0; a < WORDS; a++)
			mem[a] = 32'h5a00_0000 ^ (a << 2);
	endtask

	task automatic write_word(input int idx, input logic [31:0] word);
		mem[idx] = word;
	endtask

	initial begin
		inst_ready    = 1'b0;
		inst_valid    = 1'b0;
		inst_data     = '0;
		d_cmd_ready   = 1'b0;
		d_rdata_valid = 1'b0;
		d_rdata       = '0;
	end

	// Both ports in one process so the LFSR is stepped in a fixed order
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inst_ready    <= 1'b0;
			inst_valid    <= 1'b0;
			d_cmd_ready   <= 1'b0;
			d_rdata_valid <= 1'b0;
			i_busy = 1'b0;
			d_busy = 1'b0;
			i_cnt  = 0;
			d_cnt  = 0;
		end else begin
			inst_valid    <= 1'b0;
			d_rdata_valid <= 1'b0;

			// ******************************************************************
			// Instruction port
			// ******************************************************************
			if (inst_ready) begin
				// Request was taken at the last rising edge
				inst_ready <= 1'b0;
				i_busy = 1'b1;
				draw_delay(i_cnt);
			end else if (inst_start && !i_busy) begin
				if (i_cnt == 0) begin
					inst_ready <= 1'b1;
					i_addr = inst_addr;
				end else begin
					i_cnt--;
				end
			end
			if (i_busy) begin
				if (i_cnt == 0) begin
					inst_valid <= 1'b1;
					inst_data  <= mem[i_addr[9:2]];
					i_busy = 1'b0;
					draw_delay(i_cnt);
				end else begin
					i_cnt--;
				end
			end

			// ******************************************************************
			// Data port
			// ******************************************************************
			if (d_cmd_ready) begin
				d_cmd_ready <= 1'b0;
				if (d_op == core_pkg::MEM_WRITE)
					mem[d_a[9:2]] = (mem[d_a[9:2]] & ~lanes) | (d_wd & lanes);
				else
					d_busy = 1'b1;
				draw_delay(d_cnt);
			end else if (d_cmd != core_pkg::MEM_NONE && !d_busy) begin
				if (d_cnt == 0) begin
					d_cmd_ready <= 1'b1;
					d_op  = d_cmd;
					d_a   = d_addr;
					d_wd  = d_wdata;
					lanes = {{8{d_wmask[3]}}, {8{d_wmask[2]}}, {8{d_wmask[1]}},
						{8{d_wmask[0]}}};
				end else begin
					d_cnt--;
				end
			end
			if (d_busy) begin
				if (d_cnt == 0) begin
					d_rdata_valid <= 1'b1;
					d_rdata       <= mem[d_a[9:2]];
					d_busy = 1'b0;
					draw_delay(d_cnt);
				end else begin
					d_cnt--;
				end
			end
		end
	end

endmodule

`default_nettype wire
